/* Makefile */
TOP = dataMemPathTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG) for a pass"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dataMemPath.f -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dataMemPath.f */
+incdir+logic
logic/memTypesPkg.sv
logic/loadStoreQueue.sv
logic/dataPort.sv
logic/memController.sv
logic/byteRam.sv
logic/dataMemPath.sv
verification/dataMemPath_assertions.sv
verification/dataMemPathTb.sv

/* logic/byteRam.sv */
`timescale 1ns/1ps
`include "dataMemPath_cfg.svh"

module byteRam (
    input  logic              clk,
    input  logic              ramWe,
    input  memTypesPkg::addrT ramAddr,
    input  logic [7:0]        ramWdata,
    output logic [7:0]        ramRdata
);
    import memTypesPkg::*;

    localparam int Bytes = 2 ** `DM_ADDR_WIDTH;

    logic [7:0] mem [Bytes];

    initial begin
        for (int i = 0; i < Bytes; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Read returns the old byte when the same address is written
    always_ff @(posedge clk) begin
        if (ramWe) mem[ramAddr] <= ramWdata;
        ramRdata <= mem[ramAddr];
    end

endmodule

/* logic/dataMemPath.sv */
`timescale 1ns/1ps

module dataMemPath (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              reqValid,
    output logic              reqReady,
    input  logic              reqStore,
    input  memTypesPkg::addrT reqAddr,
    input  memTypesPkg::dataT reqData,
    input  memTypesPkg::lenT  reqLen,
    input  memTypesPkg::nickT reqNick,
    output logic              respValid,
    output memTypesPkg::dataT respData,
    output memTypesPkg::nickT respNick
);
    import memTypesPkg::*;

    logic       issueValid;
    logic       issueReady;
    logic       issueStore;
    addrT       issueAddr;
    dataT       issueData;
    lenT        issueLen;
    nickT       issueNick;
    logic       mcValid;
    logic       mcStore;
    addrT       mcAddr;
    dataT       mcWdata;
    lenT        mcLen;
    logic       mcBusy;
    logic       mcDone;
    dataT       mcRdData;
    logic       ramWe;
    addrT       ramAddr;
    logic [7:0] ramWdata;
    logic [7:0] ramRdata;

    loadStoreQueue lsq (
        .clk(clk), .rst(rst), .rdy(rdy),
        .reqValid(reqValid), .reqReady(reqReady), .reqStore(reqStore),
        .reqAddr(reqAddr), .reqData(reqData), .reqLen(reqLen), .reqNick(reqNick),
        .issueValid(issueValid), .issueReady(issueReady), .issueStore(issueStore),
        .issueAddr(issueAddr), .issueData(issueData), .issueLen(issueLen),
        .issueNick(issueNick)
    );

    dataPort port (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issueValid(issueValid), .issueReady(issueReady), .issueStore(issueStore),
        .issueAddr(issueAddr), .issueData(issueData), .issueLen(issueLen),
        .issueNick(issueNick),
        .mcValid(mcValid), .mcStore(mcStore), .mcAddr(mcAddr), .mcWdata(mcWdata),
        .mcLen(mcLen), .mcBusy(mcBusy), .mcDone(mcDone), .mcRdData(mcRdData),
        .respValid(respValid), .respData(respData), .respNick(respNick)
    );

    memController ctrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .mcValid(mcValid), .mcStore(mcStore), .mcAddr(mcAddr), .mcWdata(mcWdata),
        .mcLen(mcLen), .mcBusy(mcBusy), .mcDone(mcDone), .mcRdData(mcRdData),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    byteRam ram (
        .clk(clk),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

endmodule

/* logic/dataMemPath_cfg.svh */
`ifndef DATAMEMPATH_CFG_SVH
`define DATAMEMPATH_CFG_SVH

// Byte address width, 4 KiB of RAM
`define DM_ADDR_WIDTH 12

`define DM_DATA_WIDTH 32

// Request nickname width
`define DM_NICK_WIDTH 4

`define DM_QUEUE_DEPTH 4  // Load/store queue entries

`endif

/* logic/dataPort.sv */
`timescale 1ns/1ps

module dataPort (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              issueValid,
    output logic              issueReady,
    input  logic              issueStore,
    input  memTypesPkg::addrT issueAddr,
    input  memTypesPkg::dataT issueData,
    input  memTypesPkg::lenT  issueLen,
    input  memTypesPkg::nickT issueNick,
    output logic              mcValid,
    output logic              mcStore,
    output memTypesPkg::addrT mcAddr,
    output memTypesPkg::dataT mcWdata,
    output memTypesPkg::lenT  mcLen,
    input  logic              mcBusy,
    input  logic              mcDone,
    input  memTypesPkg::dataT mcRdData,
    output logic              respValid,
    output memTypesPkg::dataT respData,
    output memTypesPkg::nickT respNick
);
    import memTypesPkg::*;

    logic occupied;
    logic handed;   // Command already taken by the controller
    logic storeReg;
    addrT addrReg;
    dataT dataReg;
    lenT  lenReg;
    nickT nickReg;
    logic capture;

    assign issueReady = !occupied;
    assign capture    = rdy && issueValid && !occupied;

    assign mcValid = occupied && !handed;
    assign mcStore = storeReg;
    assign mcAddr  = addrReg;
    assign mcWdata = dataReg;
    assign mcLen   = lenReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            handed    <= 1'b0;
            respValid <= 1'b0;
        end else if (rdy) begin
            respValid <= mcDone;
            if (mcDone) begin
                occupied <= 1'b0;
            end else if (capture) begin
                occupied <= 1'b1;
                handed   <= 1'b0;
            end else if (mcValid && !mcBusy) begin
                handed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            storeReg <= issueStore;
            addrReg  <= issueAddr;
            dataReg  <= issueData;
            lenReg   <= issueLen;
            nickReg  <= issueNick;
        end
        if (rdy && mcDone) begin
            respData <= storeReg ? '0 : mcRdData;  // Stores answer with zero
            respNick <= nickReg;
        end
    end

endmodule

/* logic/loadStoreQueue.sv */
`timescale 1ns/1ps
`include "dataMemPath_cfg.svh"

module loadStoreQueue (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              reqValid,
    output logic              reqReady,
    input  logic              reqStore,
    input  memTypesPkg::addrT reqAddr,
    input  memTypesPkg::dataT reqData,
    input  memTypesPkg::lenT  reqLen,
    input  memTypesPkg::nickT reqNick,
    output logic              issueValid,
    input  logic              issueReady,
    output logic              issueStore,
    output memTypesPkg::addrT issueAddr,
    output memTypesPkg::dataT issueData,
    output memTypesPkg::lenT  issueLen,
    output memTypesPkg::nickT issueNick
);
    import memTypesPkg::*;

    localparam int Depth    = `DM_QUEUE_DEPTH;
    localparam int PtrWidth = $clog2(Depth);

    logic                storeMem [Depth];
    addrT                addrMem  [Depth];
    dataT                dataMem  [Depth];
    lenT                 lenMem   [Depth];
    nickT                nickMem  [Depth];
    logic [PtrWidth-1:0] head;
    logic [PtrWidth-1:0] tail;
    logic [PtrWidth:0]   count;
    logic                push;
    logic                pop;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        nextPtr = (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign reqReady   = rdy && (count != (PtrWidth + 1)'(Depth));
    assign issueValid = (count != '0);
    assign push       = reqValid && reqReady;
    assign pop        = rdy && issueValid && issueReady;

    // Head entry goes straight to the data port
    assign issueStore = storeMem[head];
    assign issueAddr  = addrMem[head];
    assign issueData  = dataMem[head];
    assign issueLen   = lenMem[head];
    assign issueNick  = nickMem[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= nextPtr(tail);
            if (pop) head <= nextPtr(head);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            storeMem[tail] <= reqStore;
            addrMem[tail]  <= reqAddr;
            dataMem[tail]  <= reqData;
            lenMem[tail]   <= reqLen;
            nickMem[tail]  <= reqNick;
        end
    end

endmodule

/* logic/memController.sv */
`timescale 1ns/1ps

module memController (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              mcValid,
    input  logic              mcStore,
    input  memTypesPkg::addrT mcAddr,
    input  memTypesPkg::dataT mcWdata,
    input  memTypesPkg::lenT  mcLen,
    output logic              mcBusy,
    output logic              mcDone,
    output memTypesPkg::dataT mcRdData,
    output logic              ramWe,
    output memTypesPkg::addrT ramAddr,
    output logic [7:0]        ramWdata,
    input  logic [7:0]        ramRdata
);
    import memTypesPkg::*;

    mcStateT    state;
    logic [1:0] cnt;       // Byte lane being read or written
    addrT       baseAddr;
    dataT       wdataReg;
    lenT        lenReg;
    dataT       rdBuf;
    logic       accept;
    logic [2:0] rdOffset;

    assign mcBusy   = (state != mcIdle);
    assign mcDone   = (state == mcFinish);
    assign mcRdData = rdBuf;
    assign accept   = rdy && mcValid && !mcBusy;

    // A pause reissues the pending byte's address so ramRdata keeps that byte
    assign rdOffset = rdy ? {1'b0, cnt} + 3'd1 : {1'b0, cnt};

    always_comb begin
        ramAddr  = mcAddr;
        ramWdata = mcWdata[7:0];
        ramWe    = 1'b0;
        case (state)
            mcIdle:   ramWe = accept && mcStore;  // Byte 0 leaves in the accept cycle
            mcRead:   ramAddr = baseAddr + addrT'(rdOffset);
            mcWrite: begin
                ramAddr  = baseAddr + addrT'(cnt);
                ramWdata = wdataReg[{cnt, 3'b000} +: 8];
                ramWe    = rdy;
            end
            mcFinish: ramWe = 1'b0;
            default:  ramWe = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mcIdle;
            cnt   <= '0;
        end else if (rdy) begin
            case (state)
                mcIdle: begin
                    if (accept && mcStore) begin
                        state <= (mcLen == 2'd0) ? mcFinish : mcWrite;
                        cnt   <= 2'd1;
                    end else if (accept) begin
                        state <= mcRead;
                        cnt   <= 2'd0;
                    end
                end
                mcRead, mcWrite: begin
                    if (cnt == lenReg) state <= mcFinish;
                    else cnt <= cnt + 2'd1;
                end
                mcFinish: state <= mcIdle;
                default:  state <= mcIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            baseAddr <= mcAddr;
            wdataReg <= mcWdata;
            lenReg   <= mcLen;
            rdBuf    <= '0;  // Zero extension for short loads
        end else if (rdy && state == mcRead) begin
            rdBuf[{cnt, 3'b000} +: 8] <= ramRdata;
        end
    end

endmodule

/* logic/memTypesPkg.sv */
`include "dataMemPath_cfg.svh"

package memTypesPkg;

    typedef logic [`DM_ADDR_WIDTH-1:0] addrT;
    typedef logic [`DM_DATA_WIDTH-1:0] dataT;
    typedef logic [`DM_NICK_WIDTH-1:0] nickT;

    // Access size as byte count minus one
    typedef logic [1:0] lenT;

    typedef enum logic [1:0] {mcIdle, mcRead, mcWrite, mcFinish} mcStateT;

endpackage

/* verification/dataMemPathTb.sv */
`timescale 1ns/1ps
`include "dataMemPath_cfg.svh"

module dataMemPathTb;
    import memTypesPkg::*;

    localparam int Timeout = 300;  // Cycles allowed for each wait

    typedef struct packed {
        logic store;
        addrT addr;
        dataT data;
        lenT  len;
        nickT nick;
    } rowT;

    logic clk;
    logic rst;
    logic rdy;
    logic reqValid;
    logic reqReady;
    logic reqStore;
    addrT reqAddr;
    dataT reqData;
    lenT  reqLen;
    nickT reqNick;
    logic respValid;
    dataT respData;
    nickT respNick;

    logic [7:0] model [2 ** `DM_ADDR_WIDTH] = '{default: 8'h00};
    logic [`DM_NICK_WIDTH+`DM_DATA_WIDTH-1:0] expected [$];  // {nick, data} in issue order
    string testName;
    int    errors    = 0;
    int    sentCount = 0;
    int    respCount = 0;
    int    sizeSel;
    logic  stallSeen = 1'b0;
    rowT   row;

    // Word store, loads of each width inside it, then narrow stores over it
    rowT stim [10] = '{
        '{1'b1, 12'h010, 32'h8765_4321, 2'd3, 4'h1},
        '{1'b0, 12'h010, 32'h0, 2'd0, 4'h2},
        '{1'b0, 12'h013, 32'h0, 2'd0, 4'h3},
        '{1'b0, 12'h011, 32'h0, 2'd1, 4'h4},
        '{1'b0, 12'h012, 32'h0, 2'd1, 4'h5},
        '{1'b0, 12'h010, 32'h0, 2'd3, 4'h6},
        '{1'b1, 12'h012, 32'hffff_ffaa, 2'd0, 4'h7},  // Only the low byte lands
        '{1'b1, 12'h00f, 32'h1234_cdef, 2'd1, 4'h8},
        '{1'b0, 12'h00e, 32'h0, 2'd3, 4'h9},
        '{1'b0, 12'h010, 32'h0, 2'd3, 4'ha}
    };

    dataMemPath DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Updates the byte model on stores, returns the zero-extended load value
    function automatic dataT modelAccess(input rowT r);
        dataT value;
        value = '0;
        for (int i = 0; i <= int'(r.len); i++) begin
            if (r.store) model[r.addr + addrT'(i)] = r.data[8*i +: 8];
            else value[8*i +: 8] = model[r.addr + addrT'(i)];
        end
        return value;
    endfunction

    task automatic finishRun();
        int assertFails;
        assertFails = DUT.handshakeChecks.failures;
        $display("Errors: %0d, assertion failures: %0d, requests: %0d, responses: %0d",
                 errors, assertFails, sentCount, respCount);
        if (errors == 0 && assertFails == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic checkTimeout(input int waited, input string what);
        if (waited > Timeout) begin
            $display("Timeout in %s while waiting for %s", testName, what);
            errors++;
            finishRun();
        end
    endtask

    task automatic sendReq(input rowT r);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        reqValid = 1'b1;
        reqStore = r.store;
        reqAddr  = r.addr;
        reqData  = r.data;
        reqLen   = r.len;
        reqNick  = r.nick;
        while (!taken) begin
            @(negedge clk);
            taken = reqReady && rdy;
            if (!reqReady && rdy) stallSeen = 1'b1;
            @(posedge clk);
            #1;
            waited++;
            if (!taken) checkTimeout(waited, "reqReady");
        end
        // In-order completion makes the model state at transfer the right one
        expected.push_back({r.nick, modelAccess(r)});
        sentCount++;
        reqValid = 1'b0;
    endtask

    task automatic drainResponses();
        int waited;
        waited = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            checkTimeout(waited, "responses");
        end
    endtask

    task automatic holdPause(input int cycles);
        logic lastResp;
        rdy      = 1'b0;
        lastResp = respValid;
        repeat (cycles) begin
            @(negedge clk);
            if (reqReady || respValid !== lastResp) begin
                $display("Pause in %s let a request or a response through", testName);
                errors++;
            end
            @(posedge clk);
            #1;
        end
        rdy = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rst && rdy && respValid) begin
            respCount++;
            if (expected.size() == 0) begin
                $display("Response in %s with nick %h arrived with none pending",
                         testName, respNick);
                errors++;
            end else begin
                if ({respNick, respData} !== expected[0]) begin
                    $display("ERROR %s: expected nick %h data %h, actual nick %h data %h",
                             testName,
                             expected[0][`DM_NICK_WIDTH+`DM_DATA_WIDTH-1 -: `DM_NICK_WIDTH],
                             expected[0][`DM_DATA_WIDTH-1:0], respNick, respData);
                    errors++;
                end
                expected.delete(0);
            end
        end
    end

    initial begin
        void'($urandom(32'ha12f_d21a));
        rst      = 1'b1;
        rdy      = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqAddr  = '0;
        reqData  = '0;
        reqLen   = '0;
        reqNick  = '0;
        testName = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (!reqReady || respValid) begin
            $display("Request side not ready or response active after reset");
            errors++;
        end
        @(posedge clk);
        #1;

        testName = "table";
        foreach (stim[i]) sendReq(stim[i]);
        drainResponses();

        // Word loads pile up behind the byte-serial controller
        testName  = "backpressure";
        stallSeen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            row = '{1'b0, addrT'(12'h010 + i), 32'h0, 2'd3, nickT'(i)};
            sendReq(row);
        end
        drainResponses();
        if (!stallSeen) begin
            $display("reqReady never dropped while the queue was full");
            errors++;
        end

        testName = "pause";
        row = '{1'b1, 12'h200, 32'h0bad_cafe, 2'd3, 4'hd};
        sendReq(row);
        row = '{1'b0, 12'h201, 32'h0, 2'd1, 4'he};
        sendReq(row);
        row = '{1'b0, 12'h200, 32'h0, 2'd3, 4'hf};
        fork
            holdPause(12);
            sendReq(row);
        join
        drainResponses();

        testName = "random";
        for (int i = 0; i < 48; i++) begin
            sizeSel   = $urandom_range(0, 2);
            row.store = 1'($urandom_range(0, 1));
            row.addr  = addrT'(12'h300 + $urandom_range(0, 31));  // Small window for overlap
            row.data  = $urandom;
            row.len   = (sizeSel == 2) ? 2'd3 : lenT'(sizeSel);
            row.nick  = nickT'(i);
            if ($urandom_range(0, 5) == 0) holdPause($urandom_range(1, 4));
            sendReq(row);
        end
        drainResponses();
        if (respCount != sentCount) begin
            $display("Sent %0d requests but saw %0d responses", sentCount, respCount);
            errors++;
        end
        finishRun();
    end

endmodule

/* verification/dataMemPath_assertions.sv */
`timescale 1ns/1ps
`include "dataMemPath_cfg.svh"

module dataMemPathAssertions (
    input logic              clk,
    input logic              rst,
    input logic              rdy,
    input logic              reqValid,
    input logic              reqReady,
    input logic              reqStore,
    input memTypesPkg::addrT reqAddr,
    input memTypesPkg::dataT reqData,
    input memTypesPkg::lenT  reqLen,
    input memTypesPkg::nickT reqNick,
    input logic              respValid,
    input logic [$clog2(`DM_QUEUE_DEPTH)-1:0] queueTail
);

    int failures = 0;  // Failed checks so far

    // A waiting request keeps its fields until it is taken
    holdFields: assert property (@(posedge clk) disable iff (rst)
        reqValid && !reqReady |=>
            reqValid && $stable({reqStore, reqAddr, reqData, reqLen, reqNick}))
        else begin
            failures++;
            $error("Request dropped or changed while waiting for reqReady");
        end

    // A paused cycle holds respValid, so only active cycles count
    singleResp: assert property (@(posedge clk) disable iff (rst)
        respValid && rdy |=> !respValid)
        else begin
            failures++;
            $error("respValid high on two consecutive active cycles");
        end

    // The queue tail only moves when a request is taken
    noPausedAccept: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> $stable(queueTail))
        else begin
            failures++;
            $error("Request accepted while rdy is low");
        end

endmodule

bind dataMemPath dataMemPathAssertions handshakeChecks (
    .clk(clk), .rst(rst), .rdy(rdy), .reqValid(reqValid), .reqReady(reqReady),
    .reqStore(reqStore), .reqAddr(reqAddr), .reqData(reqData), .reqLen(reqLen),
    .reqNick(reqNick), .respValid(respValid), .queueTail(lsq.tail)
);
